// File: src.f
src/input_pkg.sv
src/av_pkg.sv
src/key_decoder.sv
src/control_mapper.sv
src/pixel_stage.sv
src/sigma_delta_dac.sv
src/arcade_io_top.sv
test/tb_arcade_io.sv

// File: test/tb_arcade_io.sv
// Self-checking testbench for the arcade I/O glue
// Drives key events, joysticks, core pixels and audio into the top level;
// concurrent assertions compare the ports with reference models.
// Run with the file list, top module tb_arcade_io

`timescale 1ns/100ps
`default_nettype none

module tb_arcade_io
	import input_pkg::*, av_pkg::*;
();

	logic               clk_sys;
	logic               rst_n;
	key_event_t         key_event;
	logic [7:0]         joystick_0;
	logic [7:0]         joystick_1;
	logic               rotate;
	scanline_e          scanlines;
	core_pixel_t        core_pixel;
	logic [AUDIO_W-1:0] core_audio;
	player_ctrl_t       controls;
	logic               ce_pix;
	out_pixel_t         vga;
	logic               audio_l;
	logic               audio_r;

	player_ctrl_t model_keys; // Held keys as the events say
	player_ctrl_t exp_ctrl;
	player_ctrl_t ctrl_prev;
	core_pixel_t  prev_pix;   // Last pixel handed to the DUT
	logic         exp_odd;
	logic         exp_ce;
	out_pixel_t   exp_vga;
	out_pixel_t   exp_vga_q;
	int           cyc;        // Edges since reset release
	int           phase;
	int           errors;
	int           errors_at_start;
	int           tests_passed;
	int           tests_failed;
	int           audio_ones;
	int           audio_exp;
	logic         audio_done;

	// Scan code of each control bit, index is the bit position
	logic [7:0] code_tab [14] = '{KEY_CTRL, KEY_ALT, KEY_SPACE, KEY_F2, KEY_F1, KEY_ESC,
		KEY_D, KEY_A, KEY_S, KEY_W, KEY_RIGHT, KEY_LEFT, KEY_DOWN, KEY_UP};

	arcade_io_top i_dut (.*);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	// ============================================================
	// Reference models
	// ============================================================

	function automatic dir_t turn_ref(input dir_t d);
		return '{up: d.left, down: d.right, left: d.down, right: d.up};
	endfunction

	function automatic player_ctrl_t map_ref(input player_ctrl_t k, input logic [7:0] j0,
			input logic [7:0] j1, input logic rot);
		player_ctrl_t c;
		c = k;
		c.p1 = k.p1 | j0[3:0]; // Stick nibble is up, down, left, right
		c.p2 = k.p2 | j1[3:0];
		if (rot) begin
			c.p1 = turn_ref(c.p1);
			c.p2 = turn_ref(c.p2);
		end
		return c;
	endfunction

	function automatic out_pixel_t expand_ref(input core_pixel_t p, input logic odd,
			input scanline_e mode);
		logic [5:0] c [3];
		c[0] = {2{p.r}};
		c[1] = {2{p.g}};
		c[2] = {2{p.b, p.b[1]}};
		for (int i = 0; i < 3; i++) begin
			if (p.hb || p.vb)
				c[i] = '0;
			else if (odd && mode == SL_25)
				c[i] = c[i] - c[i] / 4;
			else if (odd && mode == SL_50)
				c[i] = c[i] / 2;
			else if (odd && mode == SL_75)
				c[i] = c[i] / 4;
		end
		return '{r: c[0], g: c[1], b: c[2], hs: p.hs, vs: p.vs};
	endfunction

	always_comb exp_ctrl = map_ref(model_keys, joystick_0, joystick_1, rotate);
	assign exp_ce = (cyc != 0 && cyc % CE_DIV == 0);

	always @(posedge clk_sys) begin
		if (!rst_n)
			cyc <= 0;
		else
			cyc <= cyc + 1;
		ctrl_prev <= controls;
		if (ce_pix)
			exp_vga_q <= exp_vga; // Pixel the DUT takes on this edge
	end

	// ============================================================
	// Checks
	// ============================================================

	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] got);
		$display("CHECK FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
		errors++;
	endtask

	a_reset_quiet: assert property (@(posedge clk_sys)
		phase == 1 |-> (!ce_pix && controls == '0 && vga == '0 && !audio_l))
		else report_mismatch("ce_pix,controls,vga,audio_l", 0,
			{$sampled(ce_pix), $sampled(controls), $sampled(vga), $sampled(audio_l)});

	a_key_early: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$changed(key_event.toggle) |-> ##2 (controls == ctrl_prev))
		else report_mismatch("controls", $sampled(ctrl_prev), $sampled(controls));

	a_key_latency: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$changed(key_event.toggle) |-> ##3 (controls == exp_ctrl))
		else report_mismatch("controls", $sampled(exp_ctrl), $sampled(controls));

	a_joy_follow: assert property (@(posedge clk_sys) disable iff (!rst_n)
		($changed(joystick_0) || $changed(joystick_1) || $changed(rotate)) |=>
			(controls == exp_ctrl))
		else report_mismatch("controls", $sampled(exp_ctrl), $sampled(controls));

	a_ce_period: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_pix == exp_ce)
		else report_mismatch("ce_pix", $sampled(exp_ce), $sampled(ce_pix));

	a_vga_sample: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_pix |=> (vga == exp_vga_q))
		else report_mismatch("vga", $sampled(exp_vga_q), $sampled(vga));

	a_audio_pair: assert property (@(posedge clk_sys) disable iff (!rst_n)
		audio_r == audio_l)
		else report_mismatch("audio_r", $sampled(audio_l), $sampled(audio_r));

	a_audio_count: assert property (@(posedge clk_sys) disable iff (!rst_n)
		audio_done |-> (audio_ones == audio_exp))
		else report_mismatch("audio_l ones", $sampled(audio_exp), $sampled(audio_ones));

	// ============================================================
	// Stimulus
	// ============================================================

	task automatic send_key(input logic [7:0] code, input logic pressed);
		@(negedge clk_sys);
		key_event = '{toggle: ~key_event.toggle, pressed: pressed, spare: 1'($urandom),
			code: code};
		for (int i = 0; i < 14; i++)
			if (code_tab[i] == code)
				model_keys[i] = pressed;
		repeat (5) @(negedge clk_sys); // Let the event reach controls
	endtask

	// One pixel per enable, parity follows the sync edges
	task automatic drive_pixel(input core_pixel_t p, input scanline_e mode);
		do
			@(negedge clk_sys);
		while (!ce_pix);
		if (p.vs && !prev_pix.vs)
			exp_odd = 1'b0;
		else if (p.hs && !prev_pix.hs)
			exp_odd = ~exp_odd;
		prev_pix   = p;
		core_pixel = p;
		scanlines  = mode;
		exp_vga    = expand_ref(p, exp_odd, mode);
	endtask

	task automatic run_audio(input logic [7:0] v);
		@(negedge clk_sys);
		core_audio = v;
		repeat (2) @(negedge clk_sys);
		audio_ones = 0;
		repeat (65536) begin
			@(negedge clk_sys);
			audio_ones += audio_l;
		end
		audio_exp  = {v, v};
		audio_done = 1'b1;
		@(negedge clk_sys);
		audio_done = 1'b0;
	endtask

	task automatic finish_test(input string name);
		repeat (6) @(negedge clk_sys);
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("[%0t] %s: ok", $time, name);
		end else begin
			tests_failed++;
			$display("[%0t] %s: %0d check failures", $time, name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	initial begin
		void'($urandom(32'hddba1e58));
		rst_n      = 1'b0;
		key_event  = '{toggle: 1'b1, pressed: 1'b1, spare: 1'b0, code: KEY_ESC}; // Stale
		joystick_0 = '0;
		joystick_1 = '0;
		rotate     = 1'b0;
		scanlines  = SL_OFF;
		core_pixel = '0;
		core_audio = '0;
		model_keys = '0;
		prev_pix   = '0;
		exp_odd    = 1'b0;
		exp_vga    = '0;
		audio_done = 1'b0;
		audio_ones = 0;
		audio_exp  = 0;
		errors     = 0;
		errors_at_start = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		phase      = 0;

		@(negedge clk_sys);
		phase = 1;
		repeat (7) @(negedge clk_sys);
		rst_n = 1'b1;
		repeat (4) @(negedge clk_sys);
		phase = 2;
		finish_test("reset and stale toggle");

		for (int n = 0; n < 150; n++) begin
			if ($urandom_range(4) == 0)
				send_key(8'($urandom), 1'($urandom)); // Mostly unknown codes
			else
				send_key(code_tab[$urandom_range(13)], 1'($urandom));
		end
		finish_test("key events");

		phase = 3;
		for (int n = 0; n < 8; n++) begin
			for (int k = 0; k < 14; k++)
				send_key(code_tab[k], $urandom_range(3) == 0);
			for (int m = 0; m < 20; m++) begin
				@(negedge clk_sys);
				joystick_0 = 8'($urandom);
				joystick_1 = 8'($urandom);
				if (m % 5 == 0)
					rotate = ~rotate;
				@(negedge clk_sys);
			end
		end
		@(negedge clk_sys);
		joystick_0 = '0;
		joystick_1 = '0;
		rotate     = 1'b0;
		finish_test("joysticks and rotation");

		phase = 4;
		for (int n = 0; n < 200; n++)
			drive_pixel(core_pixel_t'(12'($urandom)), SL_OFF);
		finish_test("pixel enable and color expansion");

		phase = 5;
		for (int m = 0; m < 4; m++) begin
			drive_pixel('{vs: 1'b1, vb: 1'b1, default: '0}, scanline_e'(m)); // Frame start
			drive_pixel('{vb: 1'b1, default: '0}, scanline_e'(m));
			for (int line = 0; line < 5; line++) begin
				drive_pixel('{hs: 1'b1, hb: 1'b1, default: '0}, scanline_e'(m));
				for (int x = 0; x < 6; x++)
					drive_pixel(core_pixel_t'({8'($urandom), 4'b0000}), scanline_e'(m));
			end
		end
		finish_test("scanline dimming");

		phase = 6;
		run_audio(8'h00);
		run_audio(8'h40);
		run_audio(8'hFF);
		finish_test("sigma-delta audio");

		$display("%0d tests passed, %0d failed, %0d check failures",
			tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Twice the cycle budget of the six tests at 10 ns per cycle
	initial begin
		#(2 * (20 + 1000 + 1300 + 1000 + 800 + 3 * 65600) * 10);
		$display("Watchdog expired, the tests did not finish in time");
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/arcade_io_top.sv
// Arcade core I/O glue, top level
// Keyboard and joystick input to the player control word, pixel
// enable and 6-6-6 video out, and the sigma-delta audio pins.
// The game core sits outside and feeds core_pixel and core_audio

`timescale 1ns/100ps
`default_nettype none

module arcade_io_top import input_pkg::*, av_pkg::*; (
	input  wire logic               clk_sys,
	input  wire logic               rst_n,
	// Host input
	input  key_event_t              key_event,
	input  wire logic [7:0]         joystick_0,
	input  wire logic [7:0]         joystick_1,
	input  wire logic               rotate,
	input  scanline_e               scanlines,
	// From the game core
	input  core_pixel_t             core_pixel,
	input  wire logic [AUDIO_W-1:0] core_audio,
	// To the core and the board
	output player_ctrl_t            controls,
	output logic                    ce_pix,
	output out_pixel_t              vga,
	output logic                    audio_l,
	output logic                    audio_r
);

	key_state_t key_state;
	logic       dac_bit;

	// ============================================================
	// Controls
	// ============================================================

	key_decoder i_key_decoder (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.key_event (key_event),
		.key_state (key_state)
	);

	control_mapper i_control_mapper (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.key_state  (key_state),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.controls   (controls)
	);

	// ============================================================
	// Video and audio
	// ============================================================

	pixel_stage i_pixel_stage (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.core_pixel (core_pixel),
		.scanlines  (scanlines),
		.ce_pix     (ce_pix),
		.vga        (vga)
	);

	sigma_delta_dac i_dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (core_audio),
		.bit_out (dac_bit)
	);

	// Mono core, same stream on both pins
	assign audio_l = dac_bit;
	assign audio_r = dac_bit;

endmodule

`default_nettype wire

// File: src/sigma_delta_dac.sv
// First-order sigma-delta audio DAC
// The 8-bit core sample is written twice into a 16-bit word and
// accumulated every clk_sys cycle; the carry is the one-bit output,
// which an RC filter on the board turns back into audio

`timescale 1ns/100ps
`default_nettype none

module sigma_delta_dac import av_pkg::*; (
	input  wire logic               clk_sys,
	input  wire logic               rst_n,
	input  wire logic [AUDIO_W-1:0] sample,
	output logic                    bit_out
);

	logic [DAC_W-1:0] din;
	logic [DAC_W-1:0] acc;
	logic [DAC_W:0]   sum; // Carry in the top bit

	assign din = {2{sample}}; // Full scale 'hFF maps to 'hFFFF
	assign sum = {1'b0, acc} + {1'b0, din};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc     <= '0;
			bit_out <= 1'b0;
		end else begin
			acc     <= sum[DAC_W-1:0];
			bit_out <= sum[DAC_W];
		end
	end

	// Silence gives a flat line once the last carry has left
	a_silent_low: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(sample == '0) [*2] |-> !bit_out
	) else $error("audio bit high during silence");

endmodule

`default_nettype wire

// File: src/pixel_stage.sv
// Pixel clock enable and video output stage
// Makes the pixel enable from clk_sys, samples the core pixel on it,
// blanks and expands 3-3-2 color to 6-6-6 and dims odd scanlines.
// vga updates one edge after each ce_pix pulse

`timescale 1ns/100ps
`default_nettype none

module pixel_stage import av_pkg::*; (
	input  wire logic  clk_sys,
	input  wire logic  rst_n,
	input  core_pixel_t core_pixel,
	input  scanline_e   scanlines,
	output logic        ce_pix,
	output out_pixel_t  vga
);

	logic [CE_CNT_W-1:0] ce_cnt;
	logic                hs_q;
	logic                vs_q;
	logic                line_odd;
	logic                line_odd_nxt;
	logic [2:0]          b3;
	logic [VID_W-1:0]    r_x;
	logic [VID_W-1:0]    g_x;
	logic [VID_W-1:0]    b_x;
	out_pixel_t          vga_nxt;

	function automatic logic [VID_W-1:0] dim(input logic [VID_W-1:0] c, input scanline_e mode);
		case (mode)
			SL_25:   dim = c - (c >> 2);
			SL_50:   dim = c >> 1;
			SL_75:   dim = c >> 2;
			default: dim = c;
		endcase
	endfunction

	// ============================================================
	// Pixel enable, one pulse every CE_DIV cycles
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ce_cnt <= '0;
			ce_pix <= 1'b0;
		end else begin
			ce_pix <= (ce_cnt == CE_CNT_W'(CE_DIV - 1));
			if (ce_cnt == CE_CNT_W'(CE_DIV - 1)) ce_cnt <= '0;
			else                                 ce_cnt <= ce_cnt + 1'b1;
		end
	end

	// ============================================================
	// Line parity and color path
	// ============================================================

	always_comb begin
		line_odd_nxt = line_odd;
		if (core_pixel.vs && !vs_q)      line_odd_nxt = 1'b0; // New frame
		else if (core_pixel.hs && !hs_q) line_odd_nxt = ~line_odd;
	end

	always_comb begin
		r_x = {core_pixel.r, core_pixel.r};
		g_x = {core_pixel.g, core_pixel.g};
		b3  = {core_pixel.b, core_pixel.b[1]};
		b_x = {b3, b3};
		vga_nxt.hs = core_pixel.hs;
		vga_nxt.vs = core_pixel.vs;
		if (core_pixel.hb || core_pixel.vb) begin
			vga_nxt.r = '0;
			vga_nxt.g = '0;
			vga_nxt.b = '0;
		end else if (line_odd_nxt) begin
			vga_nxt.r = dim(r_x, scanlines);
			vga_nxt.g = dim(g_x, scanlines);
			vga_nxt.b = dim(b_x, scanlines);
		end else begin
			vga_nxt.r = r_x;
			vga_nxt.g = g_x;
			vga_nxt.b = b_x;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hs_q     <= 1'b0;
			vs_q     <= 1'b0;
			line_odd <= 1'b0;
			vga      <= '0;
		end else if (ce_pix) begin
			hs_q     <= core_pixel.hs;
			vs_q     <= core_pixel.vs;
			line_odd <= line_odd_nxt;
			vga      <= vga_nxt;
		end
	end

	a_ce_spacing: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		ce_pix |=> !ce_pix [*CE_DIV-1]
	) else $error("ce_pix pulses closer than CE_DIV cycles");

	// Output only moves on the edge after a pulse
	a_vga_hold: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!ce_pix |=> $stable(vga)
	) else $error("vga changed without a pixel enable");

endmodule

`default_nettype wire

// File: src/control_mapper.sv
// Player control mapper
// Merges held keys with the two joysticks, applies the optional
// rotation for a sideways cabinet and registers the control word.
// Joystick and rotate changes show on controls one edge later

`timescale 1ns/100ps
`default_nettype none

module control_mapper import input_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       rst_n,
	input  key_state_t      key_state,
	input  wire logic [7:0] joystick_0,
	input  wire logic [7:0] joystick_1,
	input  wire logic       rotate,
	output player_ctrl_t    controls
);

	dir_t         p1_dir;
	dir_t         p2_dir;
	player_ctrl_t ctrl_nxt;

	function automatic dir_t joy_dir(input logic [7:0] joy);
		dir_t d;
		d.up    = joy[JOY_UP];
		d.down  = joy[JOY_DOWN];
		d.left  = joy[JOY_LEFT];
		d.right = joy[JOY_RIGHT];
		return d;
	endfunction

	// Quarter turn, stick left moves the sprite up
	function automatic dir_t rotate_dir(input dir_t d);
		dir_t r;
		r.up    = d.left;
		r.down  = d.right;
		r.left  = d.down;
		r.right = d.up;
		return r;
	endfunction

	always_comb begin
		p1_dir   = key_state.p1 | joy_dir(joystick_0);
		p2_dir   = key_state.p2 | joy_dir(joystick_1);
		ctrl_nxt = '{p1: rotate ? rotate_dir(p1_dir) : p1_dir,
		             p2: rotate ? rotate_dir(p2_dir) : p2_dir,
		             coin: key_state.coin, start1: key_state.start1,
		             start2: key_state.start2, fire1: key_state.fire1,
		             fire2: key_state.fire2, fire3: key_state.fire3};
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) controls <= '0;
		else        controls <= ctrl_nxt;
	end

	// Unrotated and no keys, the sticks land bit for bit
	a_joy_passthrough: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(!rotate && key_state == '0) |=>
			(controls.p1 == $past(joystick_0[3:0]) && controls.p2 == $past(joystick_1[3:0]))
	) else $error("controls do not follow joystick directions");

endmodule

`default_nettype wire

// File: src/key_decoder.sv
// Keyboard event decoder
// Registers the host key event, spots a new event by its toggle bit
// and keeps the held state of the fourteen game keys.
// key_state follows a key_event change after two clk_sys edges

`timescale 1ns/100ps
`default_nettype none

module key_decoder import input_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       rst_n,
	input  key_event_t      key_event,
	output key_state_t      key_state
);

	key_event_t ev_q;     // Registered raw event
	logic       tog_prev; // Toggle seen one cycle earlier
	logic       ev_new;

	always_ff @(posedge clk_sys) begin
		ev_q <= key_event;
	end

	assign ev_new = (ev_q.toggle != tog_prev);

	// ============================================================
	// Held key table
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			tog_prev  <= key_event.toggle; // Stale toggle must not fire on release
			key_state <= '0;
		end else begin
			tog_prev <= ev_q.toggle;
			if (ev_new) begin
				case (ev_q.code)
					KEY_UP:    key_state.p1.up    <= ev_q.pressed;
					KEY_DOWN:  key_state.p1.down  <= ev_q.pressed;
					KEY_LEFT:  key_state.p1.left  <= ev_q.pressed;
					KEY_RIGHT: key_state.p1.right <= ev_q.pressed;
					KEY_W:     key_state.p2.up    <= ev_q.pressed;
					KEY_S:     key_state.p2.down  <= ev_q.pressed;
					KEY_A:     key_state.p2.left  <= ev_q.pressed;
					KEY_D:     key_state.p2.right <= ev_q.pressed;
					KEY_ESC:   key_state.coin     <= ev_q.pressed;
					KEY_F1:    key_state.start1   <= ev_q.pressed;
					KEY_F2:    key_state.start2   <= ev_q.pressed;
					KEY_SPACE: key_state.fire1    <= ev_q.pressed;
					KEY_ALT:   key_state.fire2    <= ev_q.pressed;
					KEY_CTRL:  key_state.fire3    <= ev_q.pressed;
					default: ; // Unknown codes ignored
				endcase
			end
		end
	end

	// Held keys only move on a detected event
	a_state_needs_event: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!ev_new |=> $stable(key_state)
	) else $error("key_state changed without a key event");

endmodule

`default_nettype wire

// File: src/av_pkg.sv
// Video and audio definitions for the arcade I/O glue
// Core pixel as produced by the game, the expanded VGA word,
// the scanline modes and the pixel and audio widths

`default_nettype none

package av_pkg;

	localparam int CE_DIV   = 4;               // clk_sys cycles per pixel
	localparam int CE_CNT_W = $clog2(CE_DIV);
	localparam int VID_W    = 6;               // Output color depth
	localparam int AUDIO_W  = 8;
	localparam int DAC_W    = 16;

	// 3-3-2 pixel from the core with syncs and blanks
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		logic       hs;
		logic       vs;
		logic       hb;
		logic       vb;
	} core_pixel_t;

	typedef struct packed {
		logic [VID_W-1:0] r;
		logic [VID_W-1:0] g;
		logic [VID_W-1:0] b;
		logic             hs;
		logic             vs;
	} out_pixel_t;

	typedef enum logic [1:0] {
		SL_OFF,
		SL_25,
		SL_50,
		SL_75
	} scanline_e;

endpackage

`default_nettype wire

// File: src/input_pkg.sv
// Input side definitions for the arcade I/O glue
// Keyboard scan codes, the raw key event from the host link,
// joystick bit positions and the player control word
// Imported by the key decoder, the control mapper and the top level

`default_nettype none

package input_pkg;

	// Joystick direction bits, low nibble of joystick_0 and joystick_1
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;

	// Scan codes of the game keys
	typedef enum logic [7:0] {
		KEY_UP    = 8'h75,
		KEY_DOWN  = 8'h72,
		KEY_LEFT  = 8'h6B,
		KEY_RIGHT = 8'h74,
		KEY_W     = 8'h1D, // Player 2 up
		KEY_S     = 8'h1B,
		KEY_A     = 8'h1C,
		KEY_D     = 8'h23,
		KEY_ESC   = 8'h76, // Coin
		KEY_F1    = 8'h05, // Start 1
		KEY_F2    = 8'h06, // Start 2
		KEY_CTRL  = 8'h14, // Fire 3
		KEY_ALT   = 8'h11, // Fire 2
		KEY_SPACE = 8'h29  // Fire 1
	} key_code_e;

	// Raw host key event, new event on every toggle change
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       spare;
		logic [7:0] code;
	} key_event_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
	} dir_t;

	// Held game keys
	typedef struct packed {
		dir_t p1;
		dir_t p2;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
		logic fire3;
	} key_state_t;

	// Control word handed to the core, all active high
	typedef struct packed {
		dir_t p1;
		dir_t p2;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
		logic fire3;
	} player_ctrl_t;

endpackage

`default_nettype wire
